// File: alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu import isaPkg::*, pipePkg::*; (
  input  aluOpT  aluOp,
  input  brCondT brCond,
  input  wordT   a,
  input  wordT   b,
  output wordT   result,
  output logic   brTaken
);

  logic [4:0] shamt;
  logic       ltSigned;

  assign shamt    = b[4:0];
  assign ltSigned = $signed(a) < $signed(b);

  always_comb begin
    case (aluOp)
      aluAdd:   result = a + b;
      aluSub:   result = a - b;
      aluAnd:   result = a & b;
      aluOr:    result = a | b;
      aluXor:   result = a ^ b;
      aluSlt:   result = {31'b0, ltSigned};
      aluSltu:  result = {31'b0, a < b};
      aluSll:   result = a << shamt;
      aluSrl:   result = a >> shamt;
      aluSra:   result = wordT'($signed(a) >>> shamt);
      aluPassB: result = b;
      default:  result = a + b;
    endcase
  end

  // only meaningful when the execute slot holds a branch.
  always_comb begin
    case (brCond)
      brEq:    brTaken = (a == b);
      brNe:    brTaken = (a != b);
      brLt:    brTaken = ltSigned;
      default: brTaken = !ltSigned;
    endcase
  end

endmodule

`default_nettype wire

// File: cpuCore.sv
`timescale 1ns/100ps
`default_nettype none

module cpuCore import isaPkg::*, pipePkg::*; #(
  parameter wordT resetPc = 32'h0
) (
  input  logic clk,
  input  logic rstN,
  output wordT imemAddr,
  input  wordT imemData,
  output wordT dmemAddr,
  output wordT dmemWdata,
  output logic dmemWe,
  output logic dmemRe,
  input  wordT dmemRdata
);

  wordT   pc;
  wordT   idInstr, idPc, idRdata1, idRdata2, idImm;
  opcodeT idOpcode;
  funct3T idFunct3;
  funct7T idFunct7;
  regIdxT idRs1, idRs2, idRd;
  aluOpT  idAluOp;
  brCondT idBrCond;
  logic   idAluSrcImm, idPcToAlu, idMemRead, idMemWrite;
  logic   idMemToReg, idRegWrite, idIsBranch, idIsJal;
  logic   stall, flush;

  wordT   exPc, exRdata1, exRdata2, exImm;
  regIdxT exRs1, exRs2, exRd;
  aluOpT  exAluOp;
  brCondT exBrCond;
  logic   exAluSrcImm, exPcToAlu, exMemRead, exMemWrite;
  logic   exMemToReg, exRegWrite, exIsBranch, exIsJal;
  fwdSelT fwdA, fwdB;
  wordT   exOpA, exOpB, aluA, aluB, aluResult, exResult, brTarget;
  logic   brTaken, exTakeBranch;

  wordT   memResult, memStoreData;
  regIdxT memRd;
  logic   memMemRead, memMemWrite, memMemToReg, memRegWrite;

  wordT   wbResult, wbLoadData, wbData;
  regIdxT wbRd;
  logic   wbMemToReg, wbRegWrite;

  function automatic wordT fwdMux(fwdSelT sel, wordT regVal, wordT memVal, wordT wbVal);
    case (sel)
      fromMem: return memVal;
      fromWb:  return wbVal;
      default: return regVal;
    endcase
  endfunction

  // fetch. a redirect from execute beats the load-use hold.
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) pc <= resetPc;
    else if (flush) pc <= brTarget;
    else if (!stall) pc <= pc + 32'd4;
  end

  assign imemAddr = pc;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) idInstr <= '0; // all-zero word decodes to no control bits.
    else if (flush) idInstr <= '0;
    else if (!stall) idInstr <= imemData;
  end

  always_ff @(posedge clk) begin
    if (!stall) idPc <= pc;
  end

  assign idOpcode = idInstr[6:0];
  assign idRd     = idInstr[11:7];
  assign idFunct3 = idInstr[14:12];
  assign idRs1    = idInstr[19:15];
  assign idRs2    = idInstr[24:20];
  assign idFunct7 = idInstr[31:25];

  pipeControl pipeCtrl (
    .idOpcode(idOpcode), .idFunct3(idFunct3), .idFunct7(idFunct7),
    .idRs1(idRs1), .idRs2(idRs2), .exRs1(exRs1), .exRs2(exRs2), .exRd(exRd),
    .memRd(memRd), .wbRd(wbRd), .exMemRead(exMemRead), .memRegWrite(memRegWrite),
    .wbRegWrite(wbRegWrite), .exTakeBranch(exTakeBranch),
    .aluOp(idAluOp), .brCond(idBrCond), .aluSrcImm(idAluSrcImm), .pcToAlu(idPcToAlu),
    .memRead(idMemRead), .memWrite(idMemWrite), .memToReg(idMemToReg),
    .regWrite(idRegWrite), .isBranch(idIsBranch), .isJal(idIsJal),
    .fwdA(fwdA), .fwdB(fwdB), .stall(stall), .flush(flush)
  );

  regFile regBank (
    .clk(clk), .rstN(rstN), .rs1(idRs1), .rs2(idRs2), .rd(wbRd),
    .wdata(wbData), .we(wbRegWrite), .rdata1(idRdata1), .rdata2(idRdata2)
  );

  immGen immUnit (.instr(idInstr), .imm(idImm));

  // ID/EX. stall already arrives as zeroed controls.
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN || flush) begin
      exAluOp     <= aluAdd;
      exBrCond    <= brEq;
      exAluSrcImm <= 1'b0;
      exPcToAlu   <= 1'b0;
      exMemRead   <= 1'b0;
      exMemWrite  <= 1'b0;
      exMemToReg  <= 1'b0;
      exRegWrite  <= 1'b0;
      exIsBranch  <= 1'b0;
      exIsJal     <= 1'b0;
    end else begin
      exAluOp     <= idAluOp;
      exBrCond    <= idBrCond;
      exAluSrcImm <= idAluSrcImm;
      exPcToAlu   <= idPcToAlu;
      exMemRead   <= idMemRead;
      exMemWrite  <= idMemWrite;
      exMemToReg  <= idMemToReg;
      exRegWrite  <= idRegWrite;
      exIsBranch  <= idIsBranch;
      exIsJal     <= idIsJal;
    end
  end

  always_ff @(posedge clk) begin
    exPc     <= idPc;
    exRdata1 <= idRdata1;
    exRdata2 <= idRdata2;
    exImm    <= idImm;
    exRs1    <= idRs1;
    exRs2    <= idRs2;
    exRd     <= idRd;
  end

  // execute.
  assign exOpA = fwdMux(fwdA, exRdata1, memResult, wbData);
  assign exOpB = fwdMux(fwdB, exRdata2, memResult, wbData);
  assign aluA  = exPcToAlu ? exPc : exOpA;   // auipc.
  assign aluB  = exAluSrcImm ? exImm : exOpB;

  alu aluUnit (
    .aluOp(exAluOp), .brCond(exBrCond), .a(aluA), .b(aluB),
    .result(aluResult), .brTaken(brTaken)
  );

  assign exTakeBranch = exIsJal || (exIsBranch && brTaken);
  assign brTarget     = exPc + exImm;
  assign exResult     = exIsJal ? exPc + 32'd4 : aluResult;

  // EX/MEM.
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      memMemRead  <= 1'b0;
      memMemWrite <= 1'b0;
      memMemToReg <= 1'b0;
      memRegWrite <= 1'b0;
    end else begin
      memMemRead  <= exMemRead;
      memMemWrite <= exMemWrite;
      memMemToReg <= exMemToReg;
      memRegWrite <= exRegWrite;
    end
  end

  always_ff @(posedge clk) begin
    memResult    <= exResult;
    memStoreData <= exOpB; // forwarded rs2, not the immediate.
    memRd        <= exRd;
  end

  assign dmemAddr  = memResult;
  assign dmemWdata = memStoreData;
  assign dmemWe    = memMemWrite;
  assign dmemRe    = memMemRead;

  // MEM/WB.
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wbMemToReg <= 1'b0;
      wbRegWrite <= 1'b0;
    end else begin
      wbMemToReg <= memMemToReg;
      wbRegWrite <= memRegWrite;
    end
  end

  always_ff @(posedge clk) begin
    wbResult   <= memResult;
    wbLoadData <= dmemRdata;
    wbRd       <= memRd;
  end

  assign wbData = wbMemToReg ? wbLoadData : wbResult;

endmodule

`default_nettype wire

// File: cpuCore_props.sv
`timescale 1ns/100ps
`default_nettype none

module cpuCoreProps import isaPkg::*; (
  input logic clk,
  input logic rstN,
  input logic dmemWe,
  input logic dmemRe,
  input logic stall,
  input logic flush,
  input logic exMemWrite,
  input logic exRegWrite,
  input wordT pc
);

  // a memory slot is either a load or a store, never both.
  noDualAccess: assert property (@(posedge clk) disable iff (!rstN)
    !(dmemWe && dmemRe))
    else $error("dmemWe and dmemRe high together");

  pcHoldOnStall: assert property (@(posedge clk) disable iff (!rstN)
    $past(stall && !flush) |-> pc == $past(pc))
    else $error("pc moved during a load-use stall");

  // both younger slots turn into bubbles after a redirect.
  firstSlotBubble: assert property (@(posedge clk) disable iff (!rstN)
    $past(flush) |-> !exMemWrite && !exRegWrite)
    else $error("flushed ID/EX slot still writes");

  secondSlotBubble: assert property (@(posedge clk) disable iff (!rstN)
    $past(flush, 2) |-> !exMemWrite && !exRegWrite)
    else $error("flushed IF/ID slot still writes");

endmodule

bind cpuCore cpuCoreProps propsI (
  .clk(clk), .rstN(rstN), .dmemWe(dmemWe), .dmemRe(dmemRe), .stall(stall),
  .flush(flush), .exMemWrite(exMemWrite), .exRegWrite(exRegWrite), .pc(pc)
);

`default_nettype wire

// File: cpuCore_tb.sv
`timescale 1ns/100ps
`default_nettype none

module cpuCore_tb import isaPkg::*; ();

  localparam int numProgs  = 10;
  localparam int bodyLen   = 40;
  localparam int haltIdx   = bodyLen + 31;
  localparam int cycleNs   = 4;
  localparam int testLimit = 250;

  logic clk;
  logic rstN;
  wordT imemAddr, imemData, dmemAddr, dmemWdata, dmemRdata;
  logic dmemWe, dmemRe;

  wordT imem [256];
  wordT dmem [256];
  wordT refRegs [32];
  wordT refMem [256];
  wordT expAddr [$];
  wordT expData [$];
  wordT expLoad [$];
  logic [31:0] rngState;
  regIdxT lastRd;
  int storesSeen, testErrs, errCount, passCount;

  cpuCore #(.resetPc(32'h0)) cpuCore_i (
    .clk(clk), .rstN(rstN), .imemAddr(imemAddr), .imemData(imemData),
    .dmemAddr(dmemAddr), .dmemWdata(dmemWdata), .dmemWe(dmemWe),
    .dmemRe(dmemRe), .dmemRdata(dmemRdata)
  );

  always #(cycleNs / 2) clk = ~clk;

  assign imemData  = imem[imemAddr[9:2]];
  assign dmemRdata = dmem[dmemAddr[9:2]];

  always @(posedge clk) begin
    if (dmemWe) dmem[dmemAddr[9:2]] = dmemWdata;
  end

  function automatic logic [31:0] nextRand();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  function automatic int randBelow(int n);
    logic [31:0] r;
    r = nextRand();
    return int'(r % 32'(n));
  endfunction

  function automatic regIdxT randReg();
    return regIdxT'(1 + randBelow(31));
  endfunction

  function automatic wordT fillWord(int i);
    return (32'(i) * 32'h9e3779b1) ^ 32'h0badc0de;
  endfunction

  function automatic wordT encI(logic [11:0] imm, regIdxT rs1, funct3T f3, regIdxT rd,
                                opcodeT op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic wordT encS(logic [11:0] imm, regIdxT rs2, regIdxT rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
  endfunction

  function automatic wordT encB(logic [12:0] imm, regIdxT rs2, regIdxT rs1, funct3T f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
  endfunction

  function automatic wordT encJ(logic [20:0] imm, regIdxT rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
  endfunction

  function automatic wordT randAlu(logic dep);
    regIdxT rd, rs1, rs2;
    funct3T f3;
    logic alt;
    logic [11:0] imm;
    rd  = randReg();
    rs1 = dep ? lastRd : randReg(); // chain on the previous result.
    rs2 = (dep && randBelow(2) == 0) ? lastRd : randReg();
    f3  = funct3T'(randBelow(8));
    alt = (f3 == f3AddSub || f3 == f3SrlSra) && randBelow(2) == 0;
    lastRd = rd;
    if (randBelow(2) == 0) return {alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, opReg};
    imm = 12'(nextRand());
    if (f3 == f3Sll || f3 == f3SrlSra) imm = {1'b0, alt, 5'b0, imm[4:0]};
    return encI(imm, rs1, f3, rd, opImm);
  endfunction

  function automatic wordT randLoad();
    regIdxT rd;
    rd = randReg();
    lastRd = rd;
    return encI(12'h100 + 12'(4 * randBelow(16)), 5'd0, 3'b010, rd, opLoad);
  endfunction

  function automatic wordT randStore();
    regIdxT rs2;
    rs2 = (randBelow(2) == 0) ? lastRd : randReg();
    return encS(12'h100 + 12'(4 * randBelow(16)), rs2, 5'd0);
  endfunction

  function automatic int fwdDist(int idx);
    int k;
    k = 1 + randBelow(3); // forward only, may land on the dump.
    if (idx + k > bodyLen) k = bodyLen - idx;
    return k;
  endfunction

  function automatic wordT randBranch(int idx);
    regIdxT rs1, rs2;
    funct3T f3s [4];
    f3s = '{f3Beq, f3Bne, f3Blt, f3Bge};
    rs1 = randReg();
    rs2 = (randBelow(4) == 0) ? rs1 : randReg();
    return encB(13'(4 * fwdDist(idx)), rs2, rs1, f3s[randBelow(4)]);
  endfunction

  function automatic wordT randUpper();
    regIdxT rd;
    logic [31:0] upper;
    rd = randReg();
    lastRd = rd;
    upper = nextRand();
    return {upper[19:0], rd, (randBelow(2) == 0) ? opLui : opAuipc};
  endfunction

  function automatic void buildProgram(int kind);
    int r;
    for (int i = 0; i < 256; i++) begin
      imem[i] = '0;
      dmem[i] = fillWord(i);
    end
    lastRd = 5'd1;
    for (int i = 0; i < bodyLen; i++) begin
      r = randBelow(8);
      case (kind)
        0: imem[i] = randAlu(1'b0);
        1: imem[i] = randAlu(r < 6);
        2: imem[i] = (r < 3) ? randLoad() : (r < 5) ? randStore() : randAlu(1'b1);
        3: imem[i] = (r < 2) ? randBranch(i) :
                     (r == 2) ? encJ(21'(4 * fwdDist(i)), randReg()) :
                     (r == 3) ? randStore() : randAlu(r > 5);
        default: imem[i] = (r < 2) ? randUpper() : (r < 4) ? randStore() :
                           (r < 6) ? randLoad() : randAlu(1'b1);
      endcase
    end
    for (int i = 1; i < 32; i++) begin
      imem[bodyLen + i - 1] = encS(12'h200 + 12'(4 * (i - 1)), regIdxT'(i), 5'd0);
    end
    imem[haltIdx] = encB(13'd0, 5'd0, 5'd0, f3Beq);
  endfunction

  function automatic wordT aluRef(funct3T f3, logic alt, wordT a, wordT b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: return alt ? wordT'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // instruction-level model; collects the loads and stores in program order.
  function automatic void runReference();
    wordT rpc, ins, a, b, val, nextPc, iImm, sImm, bImm, jImm, ea;
    regIdxT rd;
    logic wr, taken;
    for (int i = 0; i < 32; i++) refRegs[i] = '0;
    for (int i = 0; i < 256; i++) refMem[i] = fillWord(i);
    expAddr.delete();
    expData.delete();
    expLoad.delete();
    rpc = '0;
    for (int step = 0; step < 2000 && rpc != 32'(haltIdx * 4); step++) begin
      ins  = imem[rpc[9:2]];
      rd   = ins[11:7];
      a    = refRegs[ins[19:15]];
      b    = refRegs[ins[24:20]];
      iImm = {{20{ins[31]}}, ins[31:20]};
      sImm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      bImm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      jImm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      nextPc = rpc + 32'd4;
      wr  = 1'b1;
      val = '0;
      case (opcodeT'(ins[6:0]))
        opLui:   val = {ins[31:12], 12'b0};
        opAuipc: val = rpc + {ins[31:12], 12'b0};
        opJal: begin
          val = rpc + 32'd4;
          nextPc = rpc + jImm;
        end
        opBranch: begin
          wr = 1'b0;
          case (ins[14:12])
            f3Beq:   taken = a == b;
            f3Bne:   taken = a != b;
            f3Blt:   taken = $signed(a) < $signed(b);
            default: taken = $signed(a) >= $signed(b);
          endcase
          if (taken) nextPc = rpc + bImm;
        end
        opLoad: begin
          ea  = a + iImm;
          val = refMem[ea[9:2]];
          expLoad.push_back(ea);
        end
        opStore: begin
          wr = 1'b0;
          ea = a + sImm;
          refMem[ea[9:2]] = b;
          expAddr.push_back(ea);
          expData.push_back(b);
        end
        opImm:   val = aluRef(ins[14:12], ins[14:12] == 3'd5 && ins[30], a, iImm);
        default: val = aluRef(ins[14:12], ins[30], a, b);
      endcase
      if (wr && rd != '0) refRegs[rd] = val;
      rpc = nextPc;
    end
  endfunction

  task automatic checkAddr(input wordT expected, input wordT actual);
    if (actual !== expected) begin
      $display("FAIL %0t dmemAddr expected %h got %h", $time, expected, actual);
      testErrs++;
    end
  endtask

  task automatic checkData(input wordT expected, input wordT actual);
    if (actual !== expected) begin
      $display("FAIL %0t dmemWdata expected %h got %h", $time, expected, actual);
      testErrs++;
    end
  endtask

  always @(negedge clk) begin
    if (rstN && dmemWe) begin
      if (expAddr.size() == 0) begin
        $display("store to %h at %0t has no matching reference store", dmemAddr, $time);
        testErrs++;
      end else begin
        checkAddr(expAddr.pop_front(), dmemAddr);
        checkData(expData.pop_front(), dmemWdata);
      end
      storesSeen++;
    end
    if (rstN && dmemRe) begin
      if (expLoad.size() == 0) begin
        $display("load from %h at %0t has no matching reference load", dmemAddr, $time);
        testErrs++;
      end else begin
        checkAddr(expLoad.pop_front(), dmemAddr);
      end
    end
  end

  initial begin
    #(numProgs * 300 * cycleNs);
    $display("watchdog: run exceeded %0d cycles", numProgs * 300);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    string kindNames [5];
    int expCount, waited;
    kindNames = '{"alu", "forwarding", "load-use", "branch/jal", "upper/mem"};
    clk = 1'b0;
    rstN = 1'b0;
    rngState = 32'h29d223c0;
    errCount = 0;
    passCount = 0;
    for (int t = 0; t < numProgs; t++) begin
      rstN = 1'b0;
      buildProgram(t % 5);
      runReference();
      expCount = expAddr.size();
      storesSeen = 0;
      testErrs = 0;
      repeat (2) @(posedge clk);
      #0.5 rstN = 1'b1;
      waited = 0;
      while (storesSeen < expCount && waited < testLimit) begin
        @(posedge clk);
        waited++;
      end
      repeat (20) @(posedge clk); // the halt loop must stay quiet.
      if (storesSeen < expCount) begin
        $display("test %0d stopped after %0d of %0d stores", t, storesSeen, expCount);
        testErrs++;
      end
      if (expLoad.size() != 0) begin
        $display("test %0d missed %0d expected loads", t, expLoad.size());
        testErrs++;
      end
      $display("test %0d (%s): %0d stores, %0d errors", t, kindNames[t % 5],
               expCount, testErrs);
      errCount += testErrs;
      if (testErrs == 0) passCount++;
      #0.5;
    end
    $display("%0d tests, %0d passed, %0d errors", numProgs, passCount, errCount);
    if (errCount == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: immGen.sv
`timescale 1ns/100ps
`default_nettype none

module immGen import isaPkg::*; (
  input  wordT instr,
  output wordT imm
);

  opcodeT opcode;

  assign opcode = instr[6:0];

  always_comb begin
    case (opcode)
      opImm, opLoad: begin
        imm = {{20{instr[31]}}, instr[31:20]};
      end
      opStore: begin
        imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      end
      opBranch: begin
        // halfword offset, bit 0 always zero.
        imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      opLui, opAuipc: begin
        imm = {instr[31:12], 12'b0};
      end
      opJal: begin
        imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      default: begin
        imm = '0; // R-type and bubbles.
      end
    endcase
  end

endmodule

`default_nettype wire

// File: isaPkg.sv
`default_nettype none

package isaPkg;

  typedef logic [31:0] wordT;   // data, address or instruction.
  typedef logic [4:0]  regIdxT;
  typedef logic [6:0]  opcodeT;
  typedef logic [2:0]  funct3T;
  typedef logic [6:0]  funct7T;

  // major opcodes of the supported subset.
  localparam opcodeT opLui    = 7'b0110111;
  localparam opcodeT opAuipc  = 7'b0010111;
  localparam opcodeT opJal    = 7'b1101111;
  localparam opcodeT opBranch = 7'b1100011;
  localparam opcodeT opLoad   = 7'b0000011;
  localparam opcodeT opStore  = 7'b0100011;
  localparam opcodeT opImm    = 7'b0010011;
  localparam opcodeT opReg    = 7'b0110011;

  localparam funct3T f3AddSub = 3'b000;
  localparam funct3T f3Sll    = 3'b001;
  localparam funct3T f3Slt    = 3'b010;
  localparam funct3T f3Sltu   = 3'b011;
  localparam funct3T f3Xor    = 3'b100;
  localparam funct3T f3SrlSra = 3'b101;
  localparam funct3T f3Or     = 3'b110;
  localparam funct3T f3And    = 3'b111;

  // branch conditions.
  localparam funct3T f3Beq = 3'b000;
  localparam funct3T f3Bne = 3'b001;
  localparam funct3T f3Blt = 3'b100;
  localparam funct3T f3Bge = 3'b101;

endpackage

`default_nettype wire

// File: pipeControl.sv
`timescale 1ns/100ps
`default_nettype none

module pipeControl import isaPkg::*, pipePkg::*; (
  input  opcodeT idOpcode,
  input  funct3T idFunct3,
  input  funct7T idFunct7,
  input  regIdxT idRs1,
  input  regIdxT idRs2,
  input  regIdxT exRs1,
  input  regIdxT exRs2,
  input  regIdxT exRd,
  input  regIdxT memRd,
  input  regIdxT wbRd,
  input  logic   exMemRead,
  input  logic   memRegWrite,
  input  logic   wbRegWrite,
  input  logic   exTakeBranch,
  output aluOpT  aluOp,
  output brCondT brCond,
  output logic   aluSrcImm,
  output logic   pcToAlu,
  output logic   memRead,
  output logic   memWrite,
  output logic   memToReg,
  output logic   regWrite,
  output logic   isBranch,
  output logic   isJal,
  output fwdSelT fwdA,
  output fwdSelT fwdB,
  output logic   stall,
  output logic   flush
);

  logic  usesRs1;
  logic  usesRs2;
  aluOpT arithOp;

  function automatic fwdSelT pickFwd(regIdxT rs);
    if (memRegWrite && memRd != '0 && memRd == rs) return fromMem; // youngest value wins.
    if (wbRegWrite && wbRd != '0 && wbRd == rs) return fromWb;
    return fromReg;
  endfunction

  assign usesRs1 = idOpcode inside {opReg, opImm, opLoad, opStore, opBranch};
  assign usesRs2 = idOpcode inside {opReg, opStore, opBranch};

  // load in execute feeding the instruction in decode.
  assign stall = exMemRead && exRd != '0 &&
                 ((usesRs1 && exRd == idRs1) || (usesRs2 && exRd == idRs2));

  assign flush = exTakeBranch;

  always_comb begin
    case (idFunct3)
      f3AddSub: arithOp = (idOpcode == opReg && idFunct7[5]) ? aluSub : aluAdd;
      f3Sll:    arithOp = aluSll;
      f3Slt:    arithOp = aluSlt;
      f3Sltu:   arithOp = aluSltu;
      f3Xor:    arithOp = aluXor;
      f3SrlSra: arithOp = idFunct7[5] ? aluSra : aluSrl; // srai carries the same bit.
      f3Or:     arithOp = aluOr;
      default:  arithOp = aluAnd;
    endcase
  end

  always_comb begin
    aluOp     = aluAdd;
    brCond    = brEq;
    aluSrcImm = 1'b0;
    pcToAlu   = 1'b0;
    memRead   = 1'b0;
    memWrite  = 1'b0;
    memToReg  = 1'b0;
    regWrite  = 1'b0;
    isBranch  = 1'b0;
    isJal     = 1'b0;
    case (idOpcode)
      opReg: begin
        aluOp    = arithOp;
        regWrite = 1'b1;
      end
      opImm: begin
        aluOp     = arithOp;
        aluSrcImm = 1'b1;
        regWrite  = 1'b1;
      end
      opLui: begin
        aluOp     = aluPassB;
        aluSrcImm = 1'b1;
        regWrite  = 1'b1;
      end
      opAuipc: begin
        pcToAlu   = 1'b1;
        aluSrcImm = 1'b1;
        regWrite  = 1'b1;
      end
      opLoad: begin
        aluSrcImm = 1'b1;
        memRead   = 1'b1;
        memToReg  = 1'b1;
        regWrite  = 1'b1;
      end
      opStore: begin
        aluSrcImm = 1'b1;
        memWrite  = 1'b1;
      end
      opBranch: begin
        isBranch = 1'b1;
        case (idFunct3)
          f3Beq:   brCond = brEq;
          f3Bne:   brCond = brNe;
          f3Blt:   brCond = brLt;
          f3Bge:   brCond = brGe;
          default: brCond = brEq;
        endcase
      end
      opJal: begin
        isJal    = 1'b1;
        regWrite = 1'b1; // link written from pc+4.
      end
      default: ;
    endcase
    if (stall) begin
      // bubble into ID/EX.
      aluOp     = aluAdd;
      brCond    = brEq;
      aluSrcImm = 1'b0;
      pcToAlu   = 1'b0;
      memRead   = 1'b0;
      memWrite  = 1'b0;
      memToReg  = 1'b0;
      regWrite  = 1'b0;
      isBranch  = 1'b0;
      isJal     = 1'b0;
    end
  end

  always_comb begin
    fwdA = pickFwd(exRs1);
    fwdB = pickFwd(exRs2);
  end

endmodule

`default_nettype wire

// File: pipePkg.sv
`default_nettype none

package pipePkg;

  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluSlt,
    aluSltu,
    aluSll,
    aluSrl,
    aluSra,
    aluPassB   // lui.
  } aluOpT;

  // where an execute operand comes from.
  typedef enum logic [1:0] {
    fromReg,
    fromMem,
    fromWb
  } fwdSelT;

  typedef enum logic [1:0] {
    brEq,
    brNe,
    brLt,
    brGe
  } brCondT;

endpackage

`default_nettype wire

// File: regFile.sv
`timescale 1ns/100ps
`default_nettype none

module regFile import isaPkg::*; (
  input  logic   clk,
  input  logic   rstN,
  input  regIdxT rs1,
  input  regIdxT rs2,
  input  regIdxT rd,
  input  wordT   wdata,
  input  logic   we,
  output wordT   rdata1,
  output wordT   rdata2
);

  wordT regs [32];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // writeback lands before decode reads in the same cycle.
  assign rdata1 = (rs1 == '0) ? '0 :
                  (we && rd == rs1) ? wdata : regs[rs1];
  assign rdata2 = (rs2 == '0) ? '0 :
                  (we && rd == rs2) ? wdata : regs[rs2];

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module cpuCore_tb -f sources.f -o simv || exit 1
out=$(./obj_dir/simv)
echo "$out"
echo "$out" | grep -qx "Done: no errors" && exit 0 || exit 1

// File: sources.f
isaPkg.sv
pipePkg.sv
pipeControl.sv
regFile.sv
immGen.sv
alu.sv
cpuCore.sv
cpuCore_props.sv
cpuCore_tb.sv
